/* copper_patterns.mem */
// Header {id[3:0], enable, frames[2:0], init_pc[7:0], words[7:0], writes[7:0]}
// then program words, then expected writes {xr_addr[15:0], xr_data[15:0]}; zero ends
// Test 1: MOVER and MOVEP from PC 0
19000302
9012abcd b0340f0f 00000003
0012abcd 80340f0f
// Test 2: back-to-back MOVEs, data filled in by the testbench generator
29400504
90010000 90020000 b0030000 90040000 00000003
00010000 00020000 80030000 00040000
// Test 3: no-op, WAIT on (2, 100), MOVER, WAIT ignoring both axes, MOVER held off
39800501
50000000 00020640 90211234 00000003 90225678
00211234
// Test 4: SKIP taken, SKIP not taken, JMP to 6, illegal opcode, MOVEP
49000902
20000000 90411111 27ff0000 90422222 400c0000 90433333 50444444 b0455555 00000003
00422222 80455555
// Test 5: initial PC 0x10, same writes in two frames
5a100304
9051a5a5 b0525a5a 00000003
0051a5a5 80525a5a 0051a5a5 80525a5a
// Test 6: enable clear, no writes
61100200
90610606 00000003
// End of list
00000000

/* vlog.f */
copper_pkg.sv
copper_sequencer.sv
copper_pc_counter.sv
copper_prog_ram.sv
copper_exec_unit.sv
copper_top.sv
copper_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
TOP       = copper_tb
FILELIST  = vlog.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* copper_tb.sv */
////////////////////////////////////////////////////////////
// Copper testbench
// Loads programs from the pattern file, runs the beam
// counters and checks every XR write against the records
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module copper_tb
    import copper_pkg::*;
();

    localparam int PC_WIDTH       = 10;
    localparam int H_TOTAL        = 800;
    localparam int V_TOTAL        = 525;
    localparam int NUM_TESTS      = 6;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    // Three frames per test
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 3 * FRAME_CYCLES;
    localparam logic [COORD_WIDTH-1:0] RESTART_H = COORD_WIDTH'(H_TOTAL - 4);
    localparam logic [COORD_WIDTH-1:0] RESTART_V = COORD_WIDTH'(V_TOTAL - 1);

    logic                     clk = 1'b0;
    logic                     copp_reset;
    logic                     ctrl_wr;
    logic [CTRL_WIDTH-1:0]    ctrl_data;
    logic                     prog_wr;
    logic [PC_WIDTH-1:0]      prog_addr;
    logic [INSN_WIDTH-1:0]    prog_data;
    logic [COORD_WIDTH-1:0]   h_count = '0;
    logic [COORD_WIDTH-1:0]   v_count = '0;
    logic                     beam_load;
    logic                     xr_wr;
    logic [XR_ADDR_WIDTH-1:0] xr_addr;
    logic [XR_DATA_WIDTH-1:0] xr_data;

    logic [31:0]            patterns [0:255];
    logic [31:0]            exp_q [$];
    logic [31:0]            rng = 32'h28a3;
    logic [COORD_WIDTH-1:0] wait_y = '0;
    logic [COORD_WIDTH-1:0] wait_x = '0;
    int    errors      = 0;
    int    cycle       = 0;
    int    restart_cyc = 0;
    int    last_wr_cyc = 0;
    int    wr_count    = 0;
    int    cur_test    = 0;
    string test_name   = "";

    always #4 clk = ~clk;

    copper_top #(
        .PC_WIDTH (PC_WIDTH),
        .H_TOTAL  (H_TOTAL),
        .V_TOTAL  (V_TOTAL)
    ) i_dut (
        .clk         (clk),
        .copp_reset  (copp_reset),
        .ctrl_wr_i   (ctrl_wr),
        .ctrl_data_i (ctrl_data),
        .prog_wr_i   (prog_wr),
        .prog_addr_i (prog_addr),
        .prog_data_i (prog_data),
        .h_count_i   (h_count),
        .v_count_i   (v_count),
        .xr_wr_o     (xr_wr),
        .xr_addr_o   (xr_addr),
        .xr_data_o   (xr_data)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Beam model; a load puts the beam just ahead of the restart point
    always @(posedge clk) begin
        if (copp_reset) begin
            h_count <= '0;
            v_count <= '0;
        end else if (beam_load) begin
            h_count <= COORD_WIDTH'(H_TOTAL - 5);
            v_count <= RESTART_V;
        end else if (h_count == COORD_WIDTH'(H_TOTAL - 1)) begin
            h_count <= '0;
            v_count <= (v_count == RESTART_V) ? '0 : v_count + COORD_WIDTH'(1);
        end else begin
            h_count <= h_count + COORD_WIDTH'(1);
        end
    end

    task automatic record_write();
        logic [31:0] expected;
        if (exp_q.size() == 0) begin
            errors++;
            $display("%s: unexpected write to %h with data %h", test_name, xr_addr, xr_data);
        end else begin
            expected = exp_q.pop_front();
            check_value({test_name, " write"}, expected, {xr_addr, xr_data});
        end
        // Strobe follows five edges after the restart sample, seen on the sixth
        if (cur_test == 2 && wr_count == 0) begin
            check_value({test_name, " first strobe delay"}, 32'd6, 32'(cycle - restart_cyc));
        end else if (cur_test == 2) begin
            check_value({test_name, " strobe spacing"}, 32'd4, 32'(cycle - last_wr_cyc));
        end
        if (cur_test == 3) begin
            check_value({test_name, " beam past wait"}, 32'd1,
                        {31'd0, (v_count >= wait_y) && (h_count >= wait_x)});
        end
        last_wr_cyc = cycle;
        wr_count++;
    endtask

    // Monitor, also the cycle count for timing and timeout
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (h_count == RESTART_H && v_count == RESTART_V) begin
            restart_cyc <= cycle;
        end
        if (xr_wr) begin
            record_write();
        end
    end

    always @(posedge clk) begin
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic run_test(input int base, output int next_base);
        logic [31:0] header;
        logic [31:0] word;
        logic [7:0]  init_pc;
        logic        enable;
        logic [15:0] move_data [$];
        int          frames;
        int          n_words;
        int          n_writes;
        header   = patterns[base];
        cur_test = int'(header[31:28]);
        enable   = header[27];
        frames   = int'(header[26:24]);
        init_pc  = header[23:16];
        n_words  = int'(header[15:8]);
        n_writes = int'(header[7:0]);
        test_name = $sformatf("test %0d", cur_test);
        wr_count  = 0;
        exp_q.delete();
        for (int i = 0; i < n_words; i++) begin
            word = patterns[base + 1 + i];
            // Random data for the MOVE words of the back-to-back test
            if (cur_test == 2 && (word[31:28] == OP_MOVER || word[31:28] == OP_MOVEP)) begin
                rng = xorshift32(rng);
                word[15:0] = rng[15:0];
                move_data.push_back(rng[15:0]);
            end
            if (cur_test == 3 && word[31:28] == OP_WAIT && word[1:0] == 2'b00) begin
                wait_y = word[26:16];
                wait_x = word[14:4];
            end
            @(posedge clk);
            prog_wr   <= 1'b1;
            prog_addr <= PC_WIDTH'(init_pc) + PC_WIDTH'(i);
            prog_data <= word;
        end
        for (int j = 0; j < n_writes; j++) begin
            word = patterns[base + 1 + n_words + j];
            if (cur_test == 2) begin
                word[15:0] = move_data.pop_front();
            end
            exp_q.push_back(word);
        end
        @(posedge clk);
        prog_wr   <= 1'b0;
        ctrl_wr   <= 1'b1;
        ctrl_data <= {enable, 7'd0, init_pc};
        beam_load <= 1'b1;
        @(posedge clk);
        ctrl_wr   <= 1'b0;
        beam_load <= 1'b0;
        @(posedge clk);
        while (!(h_count == RESTART_H && v_count == RESTART_V)) begin
            @(posedge clk);
        end
        // Stop just before the next restart after the last frame
        repeat (frames * FRAME_CYCLES - 2) @(posedge clk);
        ctrl_wr   <= 1'b1;
        ctrl_data <= '0;
        @(posedge clk);
        ctrl_wr <= 1'b0;
        if (exp_q.size() != 0) begin
            errors += exp_q.size();
            $display("%s: %0d expected writes never appeared", test_name, exp_q.size());
        end
        next_base = base + 1 + n_words + n_writes;
    endtask

    initial begin
        int base;
        int next_base;
        int tests_run;
        copp_reset <= 1'b1;
        ctrl_wr    <= 1'b0;
        ctrl_data  <= '0;
        prog_wr    <= 1'b0;
        prog_addr  <= '0;
        prog_data  <= '0;
        beam_load  <= 1'b0;
        $readmemh("copper_patterns.mem", patterns);
        repeat (5) @(posedge clk);
        copp_reset <= 1'b0;
        base      = 0;
        tests_run = 0;
        while (patterns[base] != 32'h0) begin
            run_test(base, next_base);
            base = next_base;
            tests_run++;
        end
        if (tests_run != NUM_TESTS) begin
            errors++;
            $display("Pattern file held %0d tests instead of %0d", tests_run, NUM_TESTS);
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* copper_top.sv */
////////////////////////////////////////////////////////////
// Copper top level
// Display-list coprocessor locked to the beam counters;
// connects sequencer, PC, program memory and execute unit
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module copper_top
    import copper_pkg::*;
#(
    parameter int PC_WIDTH = 10,
    parameter int H_TOTAL  = 800,
    parameter int V_TOTAL  = 525
) (
    input  logic                     clk,
    input  logic                     copp_reset,
    input  logic                     ctrl_wr_i,
    input  logic [CTRL_WIDTH-1:0]    ctrl_data_i,
    input  logic                     prog_wr_i,
    input  logic [PC_WIDTH-1:0]      prog_addr_i,
    input  logic [INSN_WIDTH-1:0]    prog_data_i,
    input  logic [COORD_WIDTH-1:0]   h_count_i,
    input  logic [COORD_WIDTH-1:0]   v_count_i,
    output logic                     xr_wr_o,
    output logic [XR_ADDR_WIDTH-1:0] xr_addr_o,
    output logic [XR_DATA_WIDTH-1:0] xr_data_o
);

    logic                  copper_en;
    logic [PC_WIDTH-1:0]   pc;
    logic [PC_WIDTH-1:0]   jmp_target;
    logic                  frame_restart;
    logic                  rd_en;
    logic                  pc_inc;
    logic                  pc_skip;
    logic                  pc_jump;
    logic                  latch_en;
    logic                  precomp_en;
    logic                  exec_en;
    logic [INSN_WIDTH-1:0] rd_data;
    opcode_e               opcode;
    logic                  cond_met;

    copper_sequencer #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) i_sequencer (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .copper_en_i     (copper_en),
        .cond_met_i      (cond_met),
        .opcode_i        (opcode),
        .h_count_i       (h_count_i),
        .v_count_i       (v_count_i),
        .frame_restart_o (frame_restart),
        .rd_en_o         (rd_en),
        .pc_inc_o        (pc_inc),
        .pc_skip_o       (pc_skip),
        .pc_jump_o       (pc_jump),
        .latch_en_o      (latch_en),
        .precomp_en_o    (precomp_en),
        .exec_en_o       (exec_en)
    );

    copper_pc_counter #(
        .PC_WIDTH (PC_WIDTH)
    ) i_pc_counter (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .ctrl_wr_i       (ctrl_wr_i),
        .frame_restart_i (frame_restart),
        .pc_inc_i        (pc_inc),
        .pc_skip_i       (pc_skip),
        .pc_jump_i       (pc_jump),
        .ctrl_data_i     (ctrl_data_i),
        .jmp_target_i    (jmp_target),
        .copper_en_o     (copper_en),
        .pc_o            (pc)
    );

    // Read address is the live PC
    copper_prog_ram #(
        .PC_WIDTH (PC_WIDTH)
    ) i_prog_ram (
        .clk       (clk),
        .wr_i      (prog_wr_i),
        .rd_en_i   (rd_en),
        .wr_addr_i (prog_addr_i),
        .rd_addr_i (pc),
        .wr_data_i (prog_data_i),
        .rd_data_o (rd_data)
    );

    copper_exec_unit #(
        .PC_WIDTH (PC_WIDTH)
    ) i_exec_unit (
        .clk          (clk),
        .copp_reset   (copp_reset),
        .latch_en_i   (latch_en),
        .precomp_en_i (precomp_en),
        .exec_en_i    (exec_en),
        .insn_i       (rd_data),
        .h_count_i    (h_count_i),
        .v_count_i    (v_count_i),
        .opcode_o     (opcode),
        .cond_met_o   (cond_met),
        .jmp_target_o (jmp_target),
        .xr_wr_o      (xr_wr_o),
        .xr_addr_o    (xr_addr_o),
        .xr_data_o    (xr_data_o)
    );

endmodule

`default_nettype wire

/* copper_exec_unit.sv */
////////////////////////////////////////////////////////////
// Copper execute unit
// Instruction register, field decode, registered beam
// compare and the XR write output register
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module copper_exec_unit
    import copper_pkg::*;
#(
    parameter int PC_WIDTH = 10
) (
    input  logic                     clk,
    input  logic                     copp_reset,
    input  logic                     latch_en_i,
    input  logic                     precomp_en_i,
    input  logic                     exec_en_i,
    input  logic [INSN_WIDTH-1:0]    insn_i,
    input  logic [COORD_WIDTH-1:0]   h_count_i,
    input  logic [COORD_WIDTH-1:0]   v_count_i,
    output opcode_e                  opcode_o,
    output logic                     cond_met_o,
    output logic [PC_WIDTH-1:0]      jmp_target_o,
    output logic                     xr_wr_o,
    output logic [XR_ADDR_WIDTH-1:0] xr_addr_o,
    output logic [XR_DATA_WIDTH-1:0] xr_data_o
);

    localparam int UPPER_WIDTH = XR_ADDR_WIDTH - MOVE_ADDR_WIDTH;

    logic [INSN_WIDTH-1:0]      insn_q;
    logic [COORD_WIDTH-1:0]     y_pos;
    logic [COORD_WIDTH-1:0]     x_pos;
    logic                       ignore_v;
    logic                       ignore_h;
    logic [MOVE_ADDR_WIDTH-1:0] move_addr;
    logic [XR_DATA_WIDTH-1:0]   move_data;
    logic                       v_reached;
    logic                       h_reached;
    logic                       wait_forever;
    logic                       cond_met_q;
    logic                       xr_wr_q;

    // Field decode from the latched word
    assign opcode_o     = opcode_e'(insn_q[OPCODE_LSB +: OPCODE_WIDTH]);
    assign y_pos        = insn_q[Y_LSB +: COORD_WIDTH];
    assign x_pos        = insn_q[X_LSB +: COORD_WIDTH];
    assign ignore_v     = insn_q[FLAG_IGNORE_V];
    assign ignore_h     = insn_q[FLAG_IGNORE_H];
    assign jmp_target_o = insn_q[JMP_LSB +: PC_WIDTH];
    assign move_addr    = insn_q[MOVE_ADDR_LSB +: MOVE_ADDR_WIDTH];
    assign move_data    = insn_q[XR_DATA_WIDTH-1:0];

    // Beam at or past the target position
    assign v_reached = v_count_i >= y_pos;
    assign h_reached = h_count_i >= x_pos;

    // WAIT ignoring both axes never completes in this frame;
    // SKIP with both ignored always skips
    assign wait_forever = (opcode_o == OP_WAIT) && ignore_v && ignore_h;

    assign cond_met_o = cond_met_q;
    assign xr_wr_o    = xr_wr_q;

    // Instruction register
    always_ff @(posedge clk) begin
        if (latch_en_i) begin
            insn_q <= insn_i;
        end
    end

    // Compare registered one cycle ahead of EXEC
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            cond_met_q <= 1'b0;
        end else if (precomp_en_i) begin
            cond_met_q <= (ignore_v || v_reached) && (ignore_h || h_reached)
                          && !wait_forever;
        end
    end

    // One-cycle write strobe, only for MOVER and MOVEP
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            xr_wr_q <= 1'b0;
        end else begin
            xr_wr_q <= exec_en_i && (opcode_o == OP_MOVER || opcode_o == OP_MOVEP);
        end
    end

    // Address and data payload
    always_ff @(posedge clk) begin
        if (exec_en_i) begin
            xr_data_o <= move_data;
            if (opcode_o == OP_MOVEP) begin
                // Palette entry in colour memory
                xr_addr_o <= {COLOR_MEM_BASE[XR_ADDR_WIDTH-1:MOVE_ADDR_WIDTH], move_addr};
            end else begin
                // XR register, upper byte zero
                xr_addr_o <= {{UPPER_WIDTH{1'b0}}, move_addr};
            end
        end
    end

endmodule

`default_nettype wire

/* copper_prog_ram.sv */
////////////////////////////////////////////////////////////
// Copper program memory
// 2^PC_WIDTH x 32-bit words, host write port and a
// registered read port with read enable
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module copper_prog_ram
    import copper_pkg::*;
#(
    parameter int PC_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  wr_i,
    input  logic                  rd_en_i,
    input  logic [PC_WIDTH-1:0]   wr_addr_i,
    input  logic [PC_WIDTH-1:0]   rd_addr_i,
    input  logic [INSN_WIDTH-1:0] wr_data_i,
    output logic [INSN_WIDTH-1:0] rd_data_o
);

    logic [INSN_WIDTH-1:0] mem [0:(2**PC_WIDTH)-1];

    // Host load port
    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Output holds its word until the next enabled read
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

/* copper_pc_counter.sv */
////////////////////////////////////////////////////////////
// Copper program counter
// Control register (enable, initial PC) and the PC with
// increment, skip, jump and frame restart loads
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module copper_pc_counter
    import copper_pkg::*;
#(
    parameter int PC_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  copp_reset,
    input  logic                  ctrl_wr_i,
    input  logic                  frame_restart_i,
    input  logic                  pc_inc_i,
    input  logic                  pc_skip_i,
    input  logic                  pc_jump_i,
    input  logic [CTRL_WIDTH-1:0] ctrl_data_i,
    input  logic [PC_WIDTH-1:0]   jmp_target_i,
    output logic                  copper_en_o,
    output logic [PC_WIDTH-1:0]   pc_o
);

    logic                copper_en_q;
    logic [PC_WIDTH-1:0] init_pc_q;
    logic [PC_WIDTH-1:0] pc_q;
    // PC + 1 precomputed ahead of EXEC for a taken SKIP
    logic [PC_WIDTH-1:0] pc_skip_q;

    assign copper_en_o = copper_en_q;
    assign pc_o        = pc_q;

    // Control register write is visible on the next cycle
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            copper_en_q <= 1'b0;
            init_pc_q   <= '0;
        end else if (ctrl_wr_i) begin
            copper_en_q <= ctrl_data_i[CTRL_EN_BIT];
            init_pc_q   <= ctrl_data_i[PC_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        pc_skip_q <= pc_q + PC_WIDTH'(1);
    end

    // Restart first, then jump, skip and plain increment
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            pc_q <= '0;
        end else if (frame_restart_i) begin
            pc_q <= init_pc_q;
        end else if (pc_jump_i) begin
            pc_q <= jmp_target_i;
        end else if (pc_skip_i) begin
            pc_q <= pc_skip_q;
        end else if (pc_inc_i) begin
            pc_q <= pc_q + PC_WIDTH'(1);
        end
    end

endmodule

`default_nettype wire

/* copper_sequencer.sv */
////////////////////////////////////////////////////////////
// Copper sequencer
// Fetch/latch/precompute/execute FSM and frame restart
// detection; steers the other blocks by one-cycle enables
////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module copper_sequencer
    import copper_pkg::*;
#(
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic                   clk,
    input  logic                   copp_reset,
    input  logic                   copper_en_i,
    input  logic                   cond_met_i,
    input  opcode_e                opcode_i,
    input  logic [COORD_WIDTH-1:0] h_count_i,
    input  logic [COORD_WIDTH-1:0] v_count_i,
    output logic                   frame_restart_o,
    output logic                   rd_en_o,
    output logic                   pc_inc_o,
    output logic                   pc_skip_o,
    output logic                   pc_jump_o,
    output logic                   latch_en_o,
    output logic                   precomp_en_o,
    output logic                   exec_en_o
);

    // Restart point, four pixels before the end of the last line
    localparam logic [COORD_WIDTH-1:0] RESTART_H = COORD_WIDTH'(H_TOTAL - 4);
    localparam logic [COORD_WIDTH-1:0] RESTART_V = COORD_WIDTH'(V_TOTAL - 1);

    seq_state_e state_q;
    seq_state_e state_d;
    logic       rd_en_q;
    logic       rd_en_d;

    assign frame_restart_o = (h_count_i == RESTART_H) && (v_count_i == RESTART_V);

    // Read strobe is high for the whole FETCH state
    assign rd_en_o = rd_en_q;

    always_comb begin
        state_d      = state_q;
        rd_en_d      = 1'b0;
        pc_inc_o     = 1'b0;
        pc_skip_o    = 1'b0;
        pc_jump_o    = 1'b0;
        latch_en_o   = 1'b0;
        precomp_en_o = 1'b0;
        exec_en_o    = 1'b0;

        case (state_q)
            ST_INIT: begin
                // Idle until enabled, then start the first fetch
                if (copper_en_i) begin
                    state_d = ST_FETCH;
                    rd_en_d = 1'b1;
                end
            end
            ST_FETCH: begin
                // Memory read completes on this edge; PC moves on
                if (copper_en_i) begin
                    pc_inc_o = 1'b1;
                    state_d  = ST_LATCH;
                end else begin
                    state_d = ST_INIT;
                end
            end
            ST_LATCH: begin
                latch_en_o = 1'b1;
                state_d    = ST_PRECOMP;
            end
            ST_PRECOMP: begin
                // Beam compare registered in the execute unit
                precomp_en_o = 1'b1;
                state_d      = ST_EXEC;
            end
            ST_EXEC: begin
                exec_en_o = 1'b1;
                // Default is to fetch the next instruction
                state_d   = ST_FETCH;
                rd_en_d   = 1'b1;
                case (opcode_i)
                    OP_WAIT: begin
                        // Position not reached, compare again
                        if (!cond_met_i) begin
                            state_d = ST_PRECOMP;
                            rd_en_d = 1'b0;
                        end
                    end
                    OP_SKIP: pc_skip_o = cond_met_i;
                    OP_JMP:  pc_jump_o = 1'b1;
                    // MOVEs and illegal codes just fetch
                    default: ;
                endcase
            end
            default: state_d = ST_INIT;
        endcase

        // Frame restart wins over everything
        if (frame_restart_o) begin
            state_d      = ST_INIT;
            rd_en_d      = 1'b0;
            pc_inc_o     = 1'b0;
            pc_skip_o    = 1'b0;
            pc_jump_o    = 1'b0;
            latch_en_o   = 1'b0;
            precomp_en_o = 1'b0;
            exec_en_o    = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            state_q <= ST_INIT;
            rd_en_q <= 1'b0;
        end else begin
            state_q <= state_d;
            rd_en_q <= rd_en_d;
        end
    end

endmodule

`default_nettype wire

/* copper_pkg.sv */
////////////////////////////////////////////////////////////
// Copper shared definitions
// Opcode and sequencer state encodings, field widths and
// bit positions of the 32-bit instruction word
////////////////////////////////////////////////////////////
`default_nettype none

package copper_pkg;

    // Instruction word is {word1, word2}, word1 in the upper half
    localparam int INSN_WIDTH     = 32;
    localparam int OPCODE_WIDTH   = 4;
    localparam int OPCODE_LSB     = 28;

    // Beam coordinates and WAIT/SKIP target positions
    localparam int COORD_WIDTH    = 11;
    localparam int Y_LSB          = 16;
    localparam int X_LSB          = 4;

    // WAIT/SKIP flag bits, in the low bits of word2
    localparam int FLAG_IGNORE_V  = 0;
    localparam int FLAG_IGNORE_H  = 1;

    // JMP target is a word address, byte address bit 16 dropped
    localparam int JMP_LSB        = 17;

    // MOVER/MOVEP register or palette byte
    localparam int MOVE_ADDR_LSB   = 16;
    localparam int MOVE_ADDR_WIDTH = 8;

    // XR write bus
    localparam int XR_ADDR_WIDTH  = 16;
    localparam int XR_DATA_WIDTH  = 16;

    // Control register: [15] enable, low bits initial PC
    localparam int CTRL_WIDTH     = 16;
    localparam int CTRL_EN_BIT    = 15;

    // Colour memory, top byte forms the MOVEP upper address
    localparam logic [XR_ADDR_WIDTH-1:0] COLOR_MEM_BASE = 16'h8000;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_WAIT  = 4'b0000,
        OP_SKIP  = 4'b0010,
        OP_JMP   = 4'b0100,
        OP_MOVER = 4'b1001,
        OP_MOVEP = 4'b1011
    } opcode_e;

    typedef enum logic [2:0] {
        ST_INIT    = 3'd0,
        ST_FETCH   = 3'd1,
        ST_LATCH   = 3'd2,
        ST_PRECOMP = 3'd3,
        ST_EXEC    = 3'd4
    } seq_state_e;

endpackage

`default_nettype wire
